// File: hw/vit_pkg.sv
package vit_pkg;

    // trellis size for constraint length 3
    localparam int NUM_STATES = 4;

    // 16 data bits plus 2 zero tail bits per frame
    localparam int FRAME_LEN = 18;
    localparam int DATA_BITS = 16;

    // index into the survivor memory, wide enough for FRAME_LEN entries
    localparam int PTR_W = 5;

    // generator taps over {u, a, b}, octal 7 and 5
    localparam logic [2:0] G0 = 3'b111;
    localparam logic [2:0] G1 = 3'b101;

    // hamming distance of one code pair, 0 to 2
    localparam int BM_W = 2;

    // 16 + 18 * 2 stays well below 64, so no normalization is needed
    localparam int PM_W = 6;

    // starting metric for the states other than 0
    localparam logic [PM_W-1:0] PM_INIT_HIGH = 6'd16;

    typedef logic [BM_W-1:0] bm_t;

    typedef logic [PM_W-1:0] pm_t;

    // one survivor bit per state, set when predecessor LSB 1 wins
    typedef logic [NUM_STATES-1:0] dec_t;

endpackage

// File: hw/vit_control.sv
module vit_control (
    input  logic clk,
    input  logic rst,
    input  logic i_en,
    input  logic i_sync,
    input  logic i_trace_last,
    output logic o_ready,
    output logic o_load,
    output logic o_init,
    output logic o_step,
    output logic o_trace,
    output logic o_frame_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_flush,
        st_trace
    } state_t;

    state_t state;
    state_t nxt_state;
    logic   accept;
    logic   done_set;

    // symbols only enter while idle or running
    assign o_ready = (state == st_idle) || (state == st_run);
    assign accept  = i_en && o_ready;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state        <= st_idle;
            o_frame_done <= 1'b0;
        end
        else if (i_en)
        begin
            state        <= nxt_state;
            o_frame_done <= done_set;
        end
    end

    // stage ramp: load, then load and step, then step alone, then trace
    always_comb
    begin
        nxt_state = state;
        o_load    = 1'b0;
        o_init    = 1'b0;
        o_step    = 1'b0;
        o_trace   = 1'b0;
        done_set  = 1'b0;
        case (state)
            st_idle:
            begin
                // first symbol of a frame also restarts metrics and pointer
                o_load = accept;
                o_init = accept;
                if (accept)
                    nxt_state = st_run;
            end
            st_run:
            begin
                o_load = i_en;
                o_step = i_en;
                if (accept && i_sync)
                    nxt_state = st_flush;
            end
            st_flush:
            begin
                // last symbol is still in the branch metric register
                o_step    = i_en;
                nxt_state = st_trace;
            end
            st_trace:
            begin
                o_trace = i_en;
                if (i_trace_last)
                begin
                    done_set  = 1'b1;
                    nxt_state = st_idle;
                end
            end
            default:
            begin
                nxt_state = st_idle;
            end
        endcase
    end

endmodule

// File: hw/vit_branch_metric.sv
module vit_branch_metric (
    input  logic          clk,
    input  logic          rst,
    input  logic          i_load,
    input  logic [1:0]    i_sym,
    output vit_pkg::bm_t  o_bm_00,
    output vit_pkg::bm_t  o_bm_01,
    output vit_pkg::bm_t  o_bm_10,
    output vit_pkg::bm_t  o_bm_11
);

    logic [1:0] sym_q;
    logic [1:0] diff_00;
    logic [1:0] diff_01;
    logic [1:0] diff_10;
    logic [1:0] diff_11;

    always_ff @(posedge clk)
    begin
        if (!rst)
            sym_q <= 2'b00;
        else if (i_load)
            sym_q <= i_sym;
    end

    // bit positions where the received pair differs from each code pair
    assign diff_00 = sym_q ^ 2'b00;
    assign diff_01 = sym_q ^ 2'b01;
    assign diff_10 = sym_q ^ 2'b10;
    assign diff_11 = sym_q ^ 2'b11;

    // popcount of a two-bit difference
    assign o_bm_00 = vit_pkg::BM_W'(diff_00[1]) + vit_pkg::BM_W'(diff_00[0]);
    assign o_bm_01 = vit_pkg::BM_W'(diff_01[1]) + vit_pkg::BM_W'(diff_01[0]);
    assign o_bm_10 = vit_pkg::BM_W'(diff_10[1]) + vit_pkg::BM_W'(diff_10[0]);
    assign o_bm_11 = vit_pkg::BM_W'(diff_11[1]) + vit_pkg::BM_W'(diff_11[0]);

endmodule

// File: hw/vit_acs.sv
module vit_acs (
    input  logic          clk,
    input  logic          rst,
    input  logic          i_init,
    input  logic          i_step,
    input  vit_pkg::bm_t  i_bm_00,
    input  vit_pkg::bm_t  i_bm_01,
    input  vit_pkg::bm_t  i_bm_10,
    input  vit_pkg::bm_t  i_bm_11,
    output vit_pkg::dec_t o_dec
);

    vit_pkg::bm_t  bm   [4];
    vit_pkg::pm_t  pm_q [vit_pkg::NUM_STATES];
    vit_pkg::pm_t  pm_d [vit_pkg::NUM_STATES];
    vit_pkg::dec_t dec;

    // branch metrics indexed by the code pair {c0, c1}
    assign bm[0] = i_bm_00;
    assign bm[1] = i_bm_01;
    assign bm[2] = i_bm_10;
    assign bm[3] = i_bm_11;

    for (genvar s = 0; s < vit_pkg::NUM_STATES; s++)
    begin : g_acs
        // encoder register {u, a, b}; state s is {u, a}, predecessor is {a, b}
        logic [2:0]   path0;
        logic [2:0]   path1;
        logic [1:0]   code0;
        logic [1:0]   code1;
        vit_pkg::pm_t sum0;
        vit_pkg::pm_t sum1;

        assign path0 = {2'(s), 1'b0};
        assign path1 = {2'(s), 1'b1};

        assign code0 = {^(path0 & vit_pkg::G0), ^(path0 & vit_pkg::G1)};
        assign code1 = {^(path1 & vit_pkg::G0), ^(path1 & vit_pkg::G1)};

        assign sum0 = pm_q[path0[1:0]] + vit_pkg::pm_t'(bm[code0]);
        assign sum1 = pm_q[path1[1:0]] + vit_pkg::pm_t'(bm[code1]);

        // strict compare so a tie keeps predecessor LSB 0
        assign dec[s]  = (sum1 < sum0);
        assign pm_d[s] = dec[s] ? sum1 : sum0;
    end

    always_ff @(posedge clk)
    begin
        if (!rst || i_init)
        begin
            // encoder starts in state 0
            for (int k = 0; k < vit_pkg::NUM_STATES; k++)
                pm_q[k] <= (k == 0) ? '0 : vit_pkg::PM_INIT_HIGH;
        end
        else if (i_step)
        begin
            pm_q <= pm_d;
        end
    end

    // written to the survivor memory at the same edge as the metric update
    assign o_dec = dec;

endmodule

// File: hw/vit_survivor_mem.sv
module vit_survivor_mem (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_init,
    input  logic                      i_step,
    input  vit_pkg::dec_t             i_dec,
    input  logic [vit_pkg::PTR_W-1:0] i_rd_idx,
    output vit_pkg::dec_t             o_rd_dec
);

    vit_pkg::dec_t             mem [vit_pkg::FRAME_LEN];
    logic [vit_pkg::PTR_W-1:0] wr_ptr;

    // one entry per trellis step of the frame
    always_ff @(posedge clk)
    begin
        if (!rst)
            wr_ptr <= '0;
        else if (i_init)
            wr_ptr <= '0;
        else if (i_step)
            wr_ptr <= wr_ptr + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (i_step)
            mem[wr_ptr] <= i_dec;
    end

    // traceback needs the decision in the same cycle it picks the index
    assign o_rd_dec = mem[i_rd_idx];

endmodule

// File: hw/vit_traceback.sv
module vit_traceback (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_trace,
    input  vit_pkg::dec_t             i_rd_dec,
    output logic [vit_pkg::PTR_W-1:0] o_rd_idx,
    output logic                      o_bit,
    output logic                      o_bit_valid,
    output logic                      o_trace_last
);

    logic [$clog2(vit_pkg::NUM_STATES)-1:0] state_q;
    logic [vit_pkg::PTR_W-1:0]              idx_q;
    logic                                   at_last;

    assign at_last = (idx_q == '0);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state_q <= '0;
            idx_q   <= vit_pkg::PTR_W'(vit_pkg::FRAME_LEN - 1);
        end
        else if (i_trace)
        begin
            if (at_last)
            begin
                // ready for the next frame, which ends in state 0 again
                state_q <= '0;
                idx_q   <= vit_pkg::PTR_W'(vit_pkg::FRAME_LEN - 1);
            end
            else
            begin
                // step back to predecessor {a, b}, b taken from the survivor bit
                state_q <= {state_q[0], i_rd_dec[state_q]};
                idx_q   <= idx_q - 1'b1;
            end
        end
    end

    assign o_rd_idx = idx_q;

    // MSB of state is the input bit that led into it
    assign o_bit = state_q[1];

    // upper two steps walk through the tail bits
    assign o_bit_valid = i_trace && (idx_q < vit_pkg::PTR_W'(vit_pkg::DATA_BITS));

    assign o_trace_last = i_trace && at_last;

endmodule

// File: hw/vit_top.sv
module vit_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_en,
    input  logic [1:0] i_sym,
    input  logic       i_sync,
    output logic       o_ready,
    output logic       o_bit,
    output logic       o_bit_valid,
    output logic       o_frame_done
);

    // stage strobes, already qualified by i_en
    logic load;
    logic init;
    logic step;
    logic trace;
    logic trace_last;

    vit_pkg::bm_t              bm_00;
    vit_pkg::bm_t              bm_01;
    vit_pkg::bm_t              bm_10;
    vit_pkg::bm_t              bm_11;
    vit_pkg::dec_t             dec;
    vit_pkg::dec_t             rd_dec;
    logic [vit_pkg::PTR_W-1:0] rd_idx;

    vit_control control_i (
        .clk          (clk),
        .rst          (rst),
        .i_en         (i_en),
        .i_sync       (i_sync),
        .i_trace_last (trace_last),
        .o_ready      (o_ready),
        .o_load       (load),
        .o_init       (init),
        .o_step       (step),
        .o_trace      (trace),
        .o_frame_done (o_frame_done)
    );

    vit_branch_metric branch_metric_i (
        .clk     (clk),
        .rst     (rst),
        .i_load  (load),
        .i_sym   (i_sym),
        .o_bm_00 (bm_00),
        .o_bm_01 (bm_01),
        .o_bm_10 (bm_10),
        .o_bm_11 (bm_11)
    );

    vit_acs acs_i (
        .clk     (clk),
        .rst     (rst),
        .i_init  (init),
        .i_step  (step),
        .i_bm_00 (bm_00),
        .i_bm_01 (bm_01),
        .i_bm_10 (bm_10),
        .i_bm_11 (bm_11),
        .o_dec   (dec)
    );

    vit_survivor_mem survivor_mem_i (
        .clk      (clk),
        .rst      (rst),
        .i_init   (init),
        .i_step   (step),
        .i_dec    (dec),
        .i_rd_idx (rd_idx),
        .o_rd_dec (rd_dec)
    );

    vit_traceback traceback_i (
        .clk          (clk),
        .rst          (rst),
        .i_trace      (trace),
        .i_rd_dec     (rd_dec),
        .o_rd_idx     (rd_idx),
        .o_bit        (o_bit),
        .o_bit_valid  (o_bit_valid),
        .o_trace_last (trace_last)
    );

endmodule

// File: verif/vit_clkgen.sv
module vit_clkgen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    // reset held low over the first three rising edges
    initial
    begin
        rst = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

// File: verif/vit_properties.sv
module vit_properties (
    input logic       clk,
    input logic       rst,
    input logic       i_en,
    input logic       i_sync,
    input logic       o_ready,
    input logic       o_frame_done,
    input logic [1:0] state
);

    timeunit 1ns;
    timeprecision 100ps;

    // encoding of the control FSM run state
    localparam logic [1:0] st_run = 2'd1;

    int   fail_count = 0;
    logic draining;

    // set by the accepted sync symbol, cleared once the frame is reported done
    always_ff @(posedge clk)
    begin
        if (!rst)
            draining <= 1'b0;
        else if (i_en && o_ready && i_sync)
            draining <= 1'b1;
        else if (o_frame_done)
            draining <= 1'b0;
    end

    sync_only_in_run: assert property (@(posedge clk) disable iff (!rst)
        (i_en && o_ready && i_sync) |-> (state == st_run))
    else
    begin
        $error("i_sync accepted outside the run state");
        fail_count++;
    end

    // back-pressure for the whole drain and traceback
    ready_low_in_trace: assert property (@(posedge clk) disable iff (!rst)
        (draining && !o_frame_done) |-> !o_ready)
    else
    begin
        $error("o_ready high during flush or traceback");
        fail_count++;
    end

    done_single_cycle: assert property (@(posedge clk) disable iff (!rst)
        (o_frame_done && i_en) |=> !o_frame_done)
    else
    begin
        $error("o_frame_done held for more than one enabled cycle");
        fail_count++;
    end

endmodule

// File: verif/vit_tb.sv
module vit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout = 200;
    localparam int code_w  = 2 * vit_pkg::FRAME_LEN;

    logic       clk;
    logic       rst;
    logic       i_en;
    logic [1:0] i_sym;
    logic       i_sync;
    logic       o_ready;
    logic       o_bit;
    logic       o_bit_valid;
    logic       o_frame_done;

    logic rx_bits[$];
    int   done_pulses;
    logic done_q;

    vit_clkgen clkgen_i (
        .clk (clk),
        .rst (rst)
    );

    vit_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .i_en         (i_en),
        .i_sym        (i_sym),
        .i_sync       (i_sync),
        .o_ready      (o_ready),
        .o_bit        (o_bit),
        .o_bit_valid  (o_bit_valid),
        .o_frame_done (o_frame_done)
    );

    bind vit_control vit_properties props_i (
        .clk          (clk),
        .rst          (rst),
        .i_en         (i_en),
        .i_sync       (i_sync),
        .o_ready      (o_ready),
        .o_frame_done (o_frame_done),
        .state        (state)
    );

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        report_error($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // reference encoder, state {a, b}, two zero tail bits, symbol k at bits 2k+1:2k
    function automatic logic [code_w-1:0] encode_frame(input logic [15:0] data);
        logic              u;
        logic              a;
        logic              b;
        logic [code_w-1:0] code;
        a = 1'b0;
        b = 1'b0;
        for (int k = 0; k < vit_pkg::FRAME_LEN; k++)
        begin
            u = (k < vit_pkg::DATA_BITS) ? data[k] : 1'b0;
            code[2*k+1] = u ^ a ^ b;
            code[2*k]   = u ^ b;
            b = a;
            a = u;
        end
        return code;
    endfunction

    function automatic logic pick_en(input int pct);
        return ($urandom % 100) >= pct;
    endfunction

    // values read here are the ones the DUT sampled on this edge
    task automatic tick();
        @(posedge clk);
        assert (dut_i.control_i.props_i.fail_count == 0)
        else
            report_error("a concurrent assertion on vit_control failed");
        if (o_bit_valid)
            rx_bits.push_back(o_bit);
        assert (!(o_bit_valid && !i_en)) else report_error("o_bit_valid rose while i_en low");
        if (o_frame_done && !done_q)
        begin
            // frame end comes with the decoder ready again
            assert (o_ready === 1'b1) else report_mismatch("o_ready", o_ready, 1);
            done_pulses++;
        end
        done_q = o_frame_done;
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (!rst)
        begin
            tick();
            waited++;
            assert (waited < timeout) else report_error("timeout waiting for reset release");
        end
    endtask

    task automatic send_frame(input logic [code_w-1:0] code, input int pct);
        int   waited;
        logic taken;
        for (int k = 0; k < vit_pkg::FRAME_LEN; k++)
        begin
            waited = 0;
            taken  = 1'b0;
            i_sym  <= code[2*k +: 2];
            i_sync <= (k == vit_pkg::FRAME_LEN - 1);
            i_en   <= pick_en(pct);
            // symbol is held until the decoder takes it
            while (!taken)
            begin
                tick();
                taken = i_en && o_ready;
                waited++;
                assert (taken || waited < timeout) else report_error("timeout waiting for o_ready");
                if (!taken)
                    i_en <= pick_en(pct);
            end
        end
    endtask

    task automatic wait_frames_done(input int frames, input int pct);
        int waited;
        waited = 0;
        i_sync <= 1'b0;
        while (done_pulses < frames)
        begin
            // no advance once all bits are out, so idle takes no stale symbol
            if (rx_bits.size() < frames * vit_pkg::DATA_BITS)
                i_en <= pick_en(pct);
            else
                i_en <= 1'b0;
            tick();
            waited++;
            assert (waited < timeout) else report_error("timeout waiting for o_frame_done");
        end
        i_en <= 1'b0;
    endtask

    // bits arrive last-first, so reverse them before comparing
    task automatic check_frame(input int frames, input int slot, input logic [15:0] data);
        logic [15:0] got;
        assert (rx_bits.size() == frames * vit_pkg::DATA_BITS)
        else
            report_mismatch("o_bit_valid count", rx_bits.size(), frames * vit_pkg::DATA_BITS);
        for (int j = 0; j < vit_pkg::DATA_BITS; j++)
            got[vit_pkg::DATA_BITS-1-j] = rx_bits[slot * vit_pkg::DATA_BITS + j];
        assert (got == data) else report_mismatch("o_bit", got, data);
    endtask

    task automatic run_frame(input logic [15:0] data, input logic [code_w-1:0] flips,
                             input int pct);
        rx_bits.delete();
        done_pulses = 0;
        send_frame(encode_frame(data) ^ flips, pct);
        wait_frames_done(1, pct);
        check_frame(1, 0, data);
    endtask

    task automatic test_reset_state();
        assert (o_ready === 1'b1) else report_mismatch("o_ready", o_ready, 1);
        assert (o_bit_valid === 1'b0) else report_mismatch("o_bit_valid", o_bit_valid, 0);
        assert (o_frame_done === 1'b0) else report_mismatch("o_frame_done", o_frame_done, 0);
    endtask

    task automatic test_clean_frames();
        run_frame(16'h0000, '0, 0);
        run_frame(16'hffff, '0, 0);
        repeat (6) run_frame(16'($urandom), '0, 0);
    endtask

    task automatic test_error_correction();
        logic [code_w-1:0] flips;
        int                i;
        int                j;
        repeat (6)
        begin
            flips = '0;
            flips[$urandom % code_w] = 1'b1;
            run_frame(16'($urandom), flips, 0);
        end
        // two flips at least 8 symbols apart
        repeat (6)
        begin
            i = $urandom % 10;
            j = i + 8 + $urandom % (10 - i);
            flips = '0;
            flips[2*i + $urandom % 2] = 1'b1;
            flips[2*j + $urandom % 2] = 1'b1;
            run_frame(16'($urandom), flips, 0);
        end
    endtask

    task automatic test_stalls();
        logic [15:0] first;
        logic [15:0] second;
        repeat (3) run_frame(16'($urandom), '0, 30);
        first  = 16'($urandom);
        second = 16'($urandom);
        rx_bits.delete();
        done_pulses = 0;
        // second frame waits at the input while the first traces back
        send_frame(encode_frame(first), 30);
        send_frame(encode_frame(second), 30);
        wait_frames_done(2, 30);
        check_frame(2, 0, first);
        check_frame(2, 1, second);
    endtask

    task automatic test_back_to_back();
        run_frame(16'hffff, '0, 0);
        run_frame(16'h0000, '0, 0);
        run_frame(16'ha5c3, '0, 0);
        run_frame(16'($urandom), '0, 0);
    endtask

    initial
    begin
        void'($urandom(32'hf602_e416));
        i_en        = 1'b0;
        i_sym       = 2'b00;
        i_sync      = 1'b0;
        done_pulses = 0;
        done_q      = 1'b0;
        wait_reset_release();
        test_reset_state();
        test_clean_frames();
        test_error_correction();
        test_stalls();
        test_back_to_back();
        tick();
        // assertion results of the last edge
        #1;
        if (dut_i.control_i.props_i.fail_count == 0)
        begin
            $display("Done: no errors");
            $finish;
        end
        else
            report_error("a concurrent assertion on vit_control failed");
    end

endmodule

// File: src.f
hw/vit_pkg.sv
hw/vit_control.sv
hw/vit_branch_metric.sv
hw/vit_acs.sv
hw/vit_survivor_mem.sv
hw/vit_traceback.sv
hw/vit_top.sv
verif/vit_clkgen.sv
verif/vit_properties.sv
verif/vit_tb.sv

// File: Bender.yml
package:
  name: vit_decoder

sources:
  - files:
      - hw/vit_pkg.sv
      - hw/vit_control.sv
      - hw/vit_branch_metric.sv
      - hw/vit_acs.sv
      - hw/vit_survivor_mem.sv
      - hw/vit_traceback.sv
      - hw/vit_top.sv
  - target: simulation
    files:
      - verif/vit_clkgen.sv
      - verif/vit_properties.sv
      - verif/vit_tb.sv
